/* logic/board_io_pkg.sv */
`default_nettype none

package board_io_pkg;

	// Board inputs
	localparam int BTN_COUNT = 4;
	localparam int SW_COUNT = 3;

	// Cycles an input must hold before the debounced copy follows
	localparam int DB_CYCLES = 16;
	localparam int DB_CNT_W = $clog2(DB_CYCLES);

	// UART bit time and 8N1 frame length
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int FRAME_BITS = 10;
	localparam int BIT_CNT_W = $clog2(FRAME_BITS);

	// Event memory size
	localparam int MEM_DEPTH = 1024;

	// Transmitter buffer depth, also the initial credit
	localparam int TX_CREDITS = 1;
	localparam int CREDIT_W = $clog2(TX_CREDITS + 1);

	// Zero field between timestamp and switches
	localparam int REC_PAD_W = 9;

	typedef logic [BTN_COUNT-1:0] btn_vec_t;
	typedef logic [SW_COUNT-1:0] sw_vec_t;
	typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;
	// One extra bit so a full log of MEM_DEPTH fits
	typedef logic [$clog2(MEM_DEPTH):0] log_count_t;
	// Record is {stamp, zero pad, switches, buttons}
	typedef logic [31:0] mem_word_t;
	typedef logic [7:0] uart_byte_t;
	typedef logic [15:0] stamp_t;

	typedef enum logic [2:0] {
		idle,
		read,
		wait_data,
		send,
		done
	} dump_state_t;

endpackage

`default_nettype wire

/* logic/btn_debounce.sv */
`default_nettype none

module btn_debounce
	import board_io_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire btn_vec_t btn,
	output btn_vec_t db_btn
);

	// Two-stage synchronizer on the raw buttons
	btn_vec_t btn_meta;
	btn_vec_t btn_sync;

	// One stability counter per button
	logic [DB_CNT_W-1:0] stable_cnt [BTN_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= btn;
			btn_sync <= btn_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			db_btn <= '0;
			for (int i = 0; i < BTN_COUNT; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < BTN_COUNT; i++) begin
				if (btn_sync[i] == db_btn[i]) begin
					// Input agrees with output, restart the window
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == DB_CNT_W'(DB_CYCLES - 1)) begin
					// Held long enough, accept the new level
					stable_cnt[i] <= '0;
					db_btn[i] <= btn_sync[i];
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/event_logger.sv */
`default_nettype none

module event_logger
	import board_io_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire btn_vec_t db_btn,
	input wire sw_vec_t switch_in,
	output logic wr_en,
	output mem_addr_t wr_addr,
	output mem_word_t wr_data,
	output log_count_t log_count,
	output logic [3:0] led_out
);

	// Switches only get a synchronizer, no debounce
	sw_vec_t sw_meta;
	sw_vec_t sw_sync;

	// Last seen input state
	btn_vec_t prev_btn;
	sw_vec_t prev_sw;

	// Free-running timestamp, wraps
	stamp_t stamp;

	logic input_changed;
	logic log_full;
	logic log_write;

	// Any edge on a debounced button or a switch
	assign input_changed = (db_btn != prev_btn) || (sw_sync != prev_sw);
	// Full memory stops logging, no wrap
	assign log_full = (log_count == log_count_t'(MEM_DEPTH));
	assign log_write = input_changed && !log_full;

	assign led_out = log_count[3:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			sw_meta <= '0;
			sw_sync <= '0;
			prev_btn <= '0;
			prev_sw <= '0;
			stamp <= '0;
		end else begin
			sw_meta <= switch_in;
			sw_sync <= sw_meta;
			prev_btn <= db_btn;
			prev_sw <= sw_sync;
			stamp <= stamp + 1'b1;
		end
	end

	// Write strobe and count move together
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_en <= 1'b0;
			log_count <= '0;
		end else begin
			wr_en <= log_write;
			if (log_write) begin
				log_count <= log_count + 1'b1;
			end
		end
	end

	// Record built from the state after the change
	always_ff @(posedge clk) begin
		if (log_write) begin
			wr_addr <= mem_addr_t'(log_count);
			wr_data <= {stamp, {REC_PAD_W{1'b0}}, sw_sync, db_btn};
		end
	end

endmodule

`default_nettype wire

/* logic/event_mem.sv */
`default_nettype none

module event_mem
	import board_io_pkg::*;
(
	input wire clk,
	input wire wr_en,
	input wire mem_addr_t wr_addr,
	input wire mem_word_t wr_data,
	input wire mem_addr_t rd_addr,
	output mem_word_t rd_data
);

	// Block RAM storage
	mem_word_t mem [MEM_DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read port, data one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* logic/dump_ctrl.sv */
`default_nettype none

module dump_ctrl
	import board_io_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire dump_req,
	input wire log_count_t log_count,
	output mem_addr_t rd_addr,
	input wire mem_word_t rd_data,
	output logic tx_valid,
	output uart_byte_t tx_data,
	input wire tx_credit,
	output logic dump_busy
);

	dump_state_t state;

	// Length latched at request, later records stay out
	log_count_t dump_len;
	log_count_t word_idx;
	logic [1:0] byte_idx;
	mem_word_t word_buf;

	// Free slots in the transmitter buffer
	logic [CREDIT_W-1:0] credit_cnt;

	logic last_byte;
	logic last_word;

	assign rd_addr = mem_addr_t'(word_idx);
	assign last_byte = (byte_idx == 2'd3);
	assign last_word = ((word_idx + 1'b1) == dump_len);

	// A byte goes out only with a credit in hand
	assign tx_valid = (state == send) && (credit_cnt != '0);
	assign dump_busy = (state != idle);

	// Most significant byte first
	always_comb begin
		case (byte_idx)
			2'd0: tx_data = word_buf[31:24];
			2'd1: tx_data = word_buf[23:16];
			2'd2: tx_data = word_buf[15:8];
			default: tx_data = word_buf[7:0];
		endcase
	end

	// Spend on a send, refill on a returned credit
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt <= CREDIT_W'(TX_CREDITS);
		end else begin
			case ({tx_valid, tx_credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			dump_len <= '0;
			word_idx <= '0;
			byte_idx <= '0;
		end else begin
			case (state)
				idle: begin
					// Requests while busy never get here
					if (dump_req) begin
						dump_len <= log_count;
						word_idx <= '0;
						byte_idx <= '0;
						state <= (log_count == '0) ? done : read;
					end
				end
				read: begin
					// Address already on rd_addr
					state <= wait_data;
				end
				wait_data: begin
					state <= send;
				end
				send: begin
					// Stall here until a credit shows up
					if (tx_valid) begin
						byte_idx <= byte_idx + 1'b1;
						if (last_byte) begin
							word_idx <= word_idx + 1'b1;
							state <= last_word ? done : read;
						end
					end
				end
				done: begin
					// All credits back means the last stop bit has ended
					if (credit_cnt == CREDIT_W'(TX_CREDITS)) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Capture the word while memory output is valid
	always_ff @(posedge clk) begin
		if (state == wait_data) begin
			word_buf <= rd_data;
		end
	end

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`default_nettype none

module uart_tx
	import board_io_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire tx_valid,
	input wire uart_byte_t tx_data,
	output logic tx_credit,
	output logic uart_tx_line
);

	// One byte of buffer ahead of the shifter
	uart_byte_t buf_data;
	logic buf_full;

	// Shifter holds stop, data and start, LSB on the line
	logic tx_active;
	logic [FRAME_BITS-1:0] frame_sr;
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [BIT_CNT_W-1:0] bit_cnt;

	logic load_frame;
	logic bit_end;

	assign load_frame = buf_full && !tx_active;
	assign bit_end = tx_active && (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
	// Ones shift in behind the frame so the line idles high
	assign uart_tx_line = frame_sr[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			buf_full <= 1'b0;
		end else begin
			buf_full <= tx_valid || (buf_full && !load_frame);
		end
	end

	always_ff @(posedge clk) begin
		if (tx_valid) begin
			buf_data <= tx_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_active <= 1'b0;
			frame_sr <= '1;
			baud_cnt <= '0;
			bit_cnt <= '0;
			tx_credit <= 1'b0;
		end else begin
			tx_credit <= 1'b0;
			if (load_frame) begin
				tx_active <= 1'b1;
				frame_sr <= {1'b1, buf_data, 1'b0};
				baud_cnt <= '0;
				bit_cnt <= '0;
			end else if (bit_end) begin
				baud_cnt <= '0;
				frame_sr <= {1'b1, frame_sr[FRAME_BITS-1:1]};
				if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
					// Stop bit done, hand the slot back
					tx_active <= 1'b0;
					tx_credit <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (tx_active) begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/board_io_top.sv */
`default_nettype none

module board_io_top
	import board_io_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire btn_vec_t btn_in,
	input wire sw_vec_t switch_in,
	input wire dump_req,
	output wire [3:0] led_out,
	output wire uart_tx_line,
	output wire dump_busy
);

	// Debounced buttons
	btn_vec_t db_btn;

	// Logger write port
	logic wr_en;
	mem_addr_t wr_addr;
	mem_word_t wr_data;
	log_count_t log_count;

	// Dump read port
	mem_addr_t rd_addr;
	mem_word_t rd_data;

	// Credit link to the transmitter
	logic tx_valid;
	uart_byte_t tx_data;
	logic tx_credit;

	btn_debounce btn_debounce_i (
		.clk(clk),
		.rst(rst),
		.btn(btn_in),
		.db_btn(db_btn)
	);

	// Change detect stands in for the core interrupt
	event_logger event_logger_i (
		.clk(clk),
		.rst(rst),
		.db_btn(db_btn),
		.switch_in(switch_in),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.log_count(log_count),
		.led_out(led_out)
	);

	event_mem event_mem_i (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	dump_ctrl dump_ctrl_i (
		.clk(clk),
		.rst(rst),
		.dump_req(dump_req),
		.log_count(log_count),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_credit(tx_credit),
		.dump_busy(dump_busy)
	);

	uart_tx uart_tx_i (
		.clk(clk),
		.rst(rst),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_credit(tx_credit),
		.uart_tx_line(uart_tx_line)
	);

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk
);

	// Period of 10 time units
	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

endmodule

`default_nettype wire

/* verification/board_io_checker.sv */
`default_nettype none

module board_io_checker
	import board_io_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire tx_valid,
	input wire tx_credit,
	input wire dump_busy,
	input wire uart_tx_line
);

	int assert_errs = 0;

	// Shadow of the credit counter seen on the link
	logic [CREDIT_W-1:0] credits;
	// Consecutive cycles with no dump running, saturates at one frame
	int idle_cycles;

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_W'(TX_CREDITS);
			idle_cycles <= 0;
		end else begin
			case ({tx_valid, tx_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			if (dump_busy) begin
				idle_cycles <= 0;
			end else if (idle_cycles < FRAME_BITS * CLKS_PER_BIT) begin
				idle_cycles <= idle_cycles + 1;
			end
		end
	end

	// A byte may only be issued with a credit in hand
	no_byte_without_credit: assert property (
		@(posedge clk) disable iff (rst) tx_valid |-> (credits != '0)
	) else begin
		assert_errs++;
		$error("tx_valid raised while no credit is held");
	end

	// Credit return lasts one cycle
	credit_single_pulse: assert property (
		@(posedge clk) disable iff (rst) tx_credit |=> !tx_credit
	) else begin
		assert_errs++;
		$error("tx_credit held for more than one cycle");
	end

	// Line idles high once a full frame has passed with no dump
	line_idle_high: assert property (
		@(posedge clk) disable iff (rst)
		(idle_cycles >= FRAME_BITS * CLKS_PER_BIT) |-> uart_tx_line
	) else begin
		assert_errs++;
		$error("uart_tx_line low while no dump is running");
	end

endmodule

`default_nettype wire

/* verification/board_io_monitor.sv */
`default_nettype none

module board_io_monitor
	import board_io_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire uart_tx_line,
	input wire dump_busy,
	input wire [3:0] led_out,
	input wire [31:0] exp_len,
	input wire [15:0] exp_fields [MEM_DEPTH],
	output int err_cnt
);

	// UART receive state, sampled on the falling edge
	logic in_frame;
	int tick;
	int bit_no;
	uart_byte_t rx_byte;

	// Word rebuild, most significant byte first
	logic [31:0] word_sr;
	int byte_cnt;
	int word_cnt;
	logic busy_q;
	stamp_t prev_stamp;
	logic have_stamp;

	initial begin
		err_cnt = 0;
	end

	task automatic report_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAIL %s: expected %h, got %h (time %0t)", name, expected, actual, $time);
		err_cnt++;
	endtask

	task automatic report_problem(input string what);
		$display("monitor: %s (time %0t)", what, $time);
		err_cnt++;
	endtask

	task automatic check_word(input logic [31:0] w);
		logic [15:0] exp_w;
		if (word_cnt >= exp_len) begin
			report_problem("more words received than were logged");
		end else begin
			exp_w = exp_fields[word_cnt];
			if (w[BTN_COUNT-1:0] != exp_w[BTN_COUNT-1:0]) begin
				report_value("record btn field", 32'(exp_w[BTN_COUNT-1:0]),
					32'(w[BTN_COUNT-1:0]));
			end
			if (w[BTN_COUNT+SW_COUNT-1:BTN_COUNT] != exp_w[BTN_COUNT+SW_COUNT-1:BTN_COUNT]) begin
				report_value("record switch field",
					32'(exp_w[BTN_COUNT+SW_COUNT-1:BTN_COUNT]),
					32'(w[BTN_COUNT+SW_COUNT-1:BTN_COUNT]));
			end
			if (w[15:BTN_COUNT+SW_COUNT] != '0) begin
				report_value("record zero field", 32'h0, 32'(w[15:BTN_COUNT+SW_COUNT]));
			end
		end
		// No wrap inside one run, so stamps only go up
		if (have_stamp && w[31:16] <= prev_stamp) begin
			report_problem($sformatf("timestamp %h not above previous %h", w[31:16], prev_stamp));
		end
		prev_stamp = w[31:16];
		have_stamp = 1'b1;
	endtask

	task automatic accept_byte();
		word_sr = {word_sr[23:0], rx_byte};
		byte_cnt++;
		if (byte_cnt == 4) begin
			check_word(word_sr);
			byte_cnt = 0;
			word_cnt++;
		end
	endtask

	task automatic sample_bit();
		if (bit_no == 0) begin
			if (uart_tx_line) begin
				report_problem("start bit not low at mid-bit");
				in_frame = 1'b0;
			end
		end else if (bit_no <= 8) begin
			// LSB arrives first
			rx_byte = {uart_tx_line, rx_byte[7:1]};
		end else begin
			in_frame = 1'b0;
			if (!uart_tx_line) begin
				report_problem("stop bit not high at mid-bit");
			end else begin
				accept_byte();
			end
		end
		bit_no++;
	endtask

	task automatic check_dump_end();
		if (byte_cnt != 0) begin
			report_problem("dump ended in the middle of a word");
		end
		if (word_cnt != exp_len) begin
			report_value("word count", exp_len, 32'(word_cnt));
		end
		if (led_out != exp_len[3:0]) begin
			report_value("led_out", 32'(exp_len[3:0]), 32'(led_out));
		end
	endtask

	always @(negedge clk) begin
		if (rst) begin
			in_frame = 1'b0;
			busy_q = 1'b0;
			byte_cnt = 0;
			word_cnt = 0;
			have_stamp = 1'b0;
		end else begin
			// Dump boundaries from dump_busy edges
			if (dump_busy && !busy_q) begin
				byte_cnt = 0;
				word_cnt = 0;
				have_stamp = 1'b0;
			end else if (!dump_busy && busy_q) begin
				check_dump_end();
			end
			busy_q = dump_busy;

			if (!in_frame) begin
				if (!uart_tx_line) begin
					// Falling edge of a start bit, aim for its middle
					in_frame = 1'b1;
					bit_no = 0;
					tick = CLKS_PER_BIT / 2 - 1;
					if (!dump_busy) begin
						report_problem("UART frame started with no dump running");
					end
				end
			end else if (tick > 1) begin
				tick--;
			end else begin
				tick = CLKS_PER_BIT;
				sample_bit();
			end
		end
	end

endmodule

`default_nettype wire

/* verification/board_io_tb.sv */
`default_nettype none

module board_io_tb
	import board_io_pkg::*;
();

	logic clk;
	logic rst;
	btn_vec_t btn_in;
	sw_vec_t switch_in;
	logic dump_req;
	wire [3:0] led_out;
	wire uart_tx_line;
	wire dump_busy;

	// Expected log handed to the monitor before each dump
	logic [15:0] exp_fields [MEM_DEPTH];
	int exp_len;
	int mon_errs;

	// Every applied input state and how long it was held
	btn_vec_t btn_q [$];
	sw_vec_t sw_q [$];
	int hold_q [$];
	btn_vec_t cur_btn;
	sw_vec_t cur_sw;

	int pass_cnt;
	int fail_cnt;
	logic hung;
	logic test_ok;

	tb_clock tb_clock_i (
		.clk(clk)
	);

	board_io_top board_io_top_i (
		.clk(clk),
		.rst(rst),
		.btn_in(btn_in),
		.switch_in(switch_in),
		.dump_req(dump_req),
		.led_out(led_out),
		.uart_tx_line(uart_tx_line),
		.dump_busy(dump_busy)
	);

	board_io_monitor board_io_monitor_i (
		.clk(clk),
		.rst(rst),
		.uart_tx_line(uart_tx_line),
		.dump_busy(dump_busy),
		.led_out(led_out),
		.exp_len(exp_len),
		.exp_fields(exp_fields),
		.err_cnt(mon_errs)
	);

	bind board_io_top board_io_checker board_io_checker_i (
		.clk(clk),
		.rst(rst),
		.tx_valid(tx_valid),
		.tx_credit(tx_credit),
		.dump_busy(dump_busy),
		.uart_tx_line(uart_tx_line)
	);

	// Walk the applied states and list the records the board should log
	function automatic int expected_log();
		btn_vec_t last_btn;
		sw_vec_t last_sw;
		int n;
		last_btn = '0;
		last_sw = '0;
		n = 0;
		for (int i = 0; i < btn_q.size(); i++) begin
			// Switches are only synchronized, they arrive first
			if (sw_q[i] != last_sw) begin
				last_sw = sw_q[i];
				exp_fields[n] = {9'd0, last_sw, last_btn};
				n++;
			end
			// Short button pulses never pass the debouncer
			if (hold_q[i] >= DB_CYCLES && btn_q[i] != last_btn) begin
				last_btn = btn_q[i];
				exp_fields[n] = {9'd0, last_sw, last_btn};
				n++;
			end
		end
		return n;
	endfunction

	function automatic int hold_len();
		return $urandom_range(DB_CYCLES + 24, DB_CYCLES + 5);
	endfunction

	function automatic string test_name(input int t);
		case (t)
			1: return "empty dump after reset";
			2: return "held button patterns";
			3: return "button glitches";
			4: return "switch changes";
			5: return "mixed changes and timestamps";
			default: return "second dump of whole log";
		endcase
	endfunction

	// Drive on the falling edge and keep the state for the reference
	task automatic apply_inputs(input btn_vec_t b, input sw_vec_t s, input int hold);
		@(negedge clk);
		btn_in = b;
		switch_in = s;
		cur_btn = b;
		cur_sw = s;
		btn_q.push_back(b);
		sw_q.push_back(s);
		hold_q.push_back(hold);
		repeat (hold - 1) @(negedge clk);
	endtask

	task automatic change_buttons();
		apply_inputs(cur_btn ^ btn_vec_t'($urandom_range((1 << BTN_COUNT) - 1, 1)), cur_sw,
			hold_len());
	endtask

	task automatic change_switches();
		apply_inputs(cur_btn, cur_sw ^ sw_vec_t'($urandom_range((1 << SW_COUNT) - 1, 1)),
			hold_len());
	endtask

	task automatic change_both();
		apply_inputs(cur_btn ^ btn_vec_t'($urandom_range((1 << BTN_COUNT) - 1, 1)),
			cur_sw ^ sw_vec_t'($urandom_range((1 << SW_COUNT) - 1, 1)), hold_len());
	endtask

	// One button flips for less than the debounce window, then returns
	task automatic glitch_button();
		btn_vec_t mask;
		btn_vec_t steady;
		mask = btn_vec_t'(1 << $urandom_range(BTN_COUNT - 1, 0));
		steady = cur_btn;
		apply_inputs(steady ^ mask, cur_sw, $urandom_range(DB_CYCLES - 4, 1));
		apply_inputs(steady, cur_sw, hold_len());
	endtask

	task automatic run_dump(output logic ok);
		int limit;
		int cycles;
		int errs_before;
		int chk_before;
		logic started;
		exp_len = expected_log();
		errs_before = mon_errs;
		chk_before = board_io_top_i.board_io_checker_i.assert_errs;
		limit = (exp_len + 1) * 4 * (FRAME_BITS * CLKS_PER_BIT + 8) + 50;
		@(negedge clk);
		dump_req = 1'b1;
		@(negedge clk);
		dump_req = 1'b0;
		started = dump_busy;
		if (!started) begin
			$display("dump_busy did not rise after the request");
		end
		cycles = 0;
		while (dump_busy && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (dump_busy) begin
			$display("timeout: dump_busy still high after %0d cycles", cycles);
			hung = 1'b1;
		end
		// Let the monitor close the dump
		repeat (2) @(negedge clk);
		ok = started && !hung && (mon_errs == errs_before)
			&& (board_io_top_i.board_io_checker_i.assert_errs == chk_before);
	endtask

	task automatic run_test(input int t, output logic ok);
		case (t)
			2: for (int i = 0; i < 6; i++) change_buttons();
			3: for (int i = 0; i < 4; i++) glitch_button();
			4: for (int i = 0; i < 4; i++) change_switches();
			5: begin
				for (int i = 0; i < 3; i++) begin
					change_buttons();
					change_switches();
					change_both();
				end
			end
			6: for (int i = 0; i < 3; i++) change_buttons();
			default: begin
			end
		endcase
		run_dump(ok);
	endtask

	initial begin
		void'($urandom(32'hec81));
		rst = 1'b1;
		btn_in = '0;
		switch_in = '0;
		dump_req = 1'b0;
		cur_btn = '0;
		cur_sw = '0;
		exp_len = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		hung = 1'b0;
		// Reset held for 8 clock cycles
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
		end
		rst = 1'b0;

		for (int t = 1; t <= 6; t++) begin
			if (hung) begin
				fail_cnt++;
				$display("test %0d %s: skipped after timeout", t, test_name(t));
			end else begin
				run_test(t, test_ok);
				if (test_ok) begin
					pass_cnt++;
				end else begin
					fail_cnt++;
				end
				$display("test %0d %s: %s (%0d words)", t, test_name(t),
					test_ok ? "ok" : "failed", exp_len);
			end
		end

		$display("summary: %0d passed, %0d failed, %0d monitor errors, %0d assertion errors",
			pass_cnt, fail_cnt, mon_errs, board_io_top_i.board_io_checker_i.assert_errs);
		if (fail_cnt == 0 && !hung && mon_errs == 0
				&& board_io_top_i.board_io_checker_i.assert_errs == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* board_io.f */
logic/board_io_pkg.sv
logic/btn_debounce.sv
logic/event_logger.sv
logic/event_mem.sv
logic/dump_ctrl.sv
logic/uart_tx.sv
logic/board_io_top.sv
verification/tb_clock.sv
verification/board_io_checker.sv
verification/board_io_monitor.sv
verification/board_io_tb.sv

/* build.sh */
#!/bin/sh
# Build and run the board_io simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module board_io_tb \
	-f board_io.f \
	--Mdir "$BUILD_DIR" -o board_io_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"$BUILD_DIR"/board_io_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	exit 1
fi
exit 0
